/* hw/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Address split of a 16-bit byte address.
`define CACHE_TAG_BITS    6
`define CACHE_INDEX_BITS  6
`define CACHE_WORD_BITS   3

// Cache geometry, per way.
`define CACHE_SETS        64
`define CACHE_BLOCK_WORDS 8

// Cycles from a fill request to the first returned word.
`define MEM_LATENCY       4

// Main memory depth in 16-bit words.
`define MEM_WORDS         32768

`endif

/* hw/cache_pkg.sv */
`include "cache_consts.svh"

package cache_pkg;

    // Processor byte address as the cache decodes it.
    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]   tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [`CACHE_WORD_BITS-1:0]  word_sel;
        logic                         byte_sel;
    } cache_addr_t;

    // One metadata entry. Bit 6 is spare.
    typedef struct packed {
        logic                       valid;
        logic                       spare;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } meta_t;

    // Write-through request to main memory, word addressed.
    typedef struct packed {
        logic        we;
        logic [14:0] addr;
        logic [15:0] data;
    } mem_wr_t;

    // One word of a block fill, aimed at one way of the data arrays.
    typedef struct packed {
        logic                         we;
        logic                         way;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [`CACHE_WORD_BITS-1:0]  word_sel;
        logic [15:0]                  data;
    } fill_wr_t;

endpackage

/* hw/data_array.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module data_array (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  block,
    input  logic [2:0]  word_sel,
    input  logic        wr_en,
    input  logic [15:0] wr_data,
    output logic [15:0] rd_data
);

    localparam int DEPTH = `CACHE_SETS * `CACHE_BLOCK_WORDS;

    logic [15:0] words [DEPTH];
    logic [8:0]  word_addr;

    // Word address within this way is block number then word.
    assign word_addr = {block, word_sel};

    assign rd_data = words[word_addr];

    // No write takes effect while rst_n is low.
    always_ff @(posedge clk) begin
        if (rst_n && wr_en) begin
            words[word_addr] <= wr_data;
        end
    end

endmodule

/* hw/meta_array.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module meta_array
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [5:0] index,
    input  logic       wr_en,
    input  meta_t      wr_meta,
    output meta_t      rd_meta
);

    logic [`CACHE_SETS-1:0]     valid_q;
    logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_SETS];

    always_comb begin
        rd_meta       = '0;
        rd_meta.valid = valid_q[index];
        rd_meta.tag   = tags[index];
    end

    // Reset clears every valid bit.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[index] <= wr_meta.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[index] <= wr_meta.tag;
        end
    end

endmodule

/* hw/d_cache.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module d_cache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cache_addr_t addr,
    input  logic [15:0] data_in,
    input  logic        read_en,
    input  logic        write_en,
    output logic [15:0] data_out,
    output logic        hit,
    output logic        miss,
    output logic        stall,
    input  logic        fill_busy,
    input  fill_wr_t    fill_wr,
    input  meta_t       meta_wr,
    output logic        fill_start,
    output logic [14:0] fill_addr,
    output logic        victim_way,
    output mem_wr_t     mem_wr
);

    logic [`CACHE_SETS-1:0] mru_q;

    logic [5:0]  data_index;
    logic [2:0]  data_word;
    logic [5:0]  meta_index;
    logic [15:0] data_way [2];
    meta_t       meta_way [2];
    logic [1:0]  hit_way;
    logic [1:0]  data_we;
    logic [1:0]  meta_we;
    logic [15:0] data_wr;
    logic        write_ok;
    logic        write_hit;
    logic        read_hit;

    // The fill owns the data arrays while it runs. The metadata follows the
    // processor address except on the cycle the tag is installed.
    assign data_index = fill_busy ? fill_wr.index : addr.index;
    assign data_word  = fill_busy ? fill_wr.word_sel : addr.word_sel;
    assign data_wr    = fill_busy ? fill_wr.data : data_in;
    assign meta_index = meta_wr.valid ? fill_wr.index : addr.index;

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign hit_way[w] = meta_way[w].valid && (meta_way[w].tag == addr.tag);
        assign data_we[w] = (fill_wr.we && (fill_wr.way == w)) || (write_hit && hit_way[w]);
        assign meta_we[w] = meta_wr.valid && (fill_wr.way == w);

        data_array u_data (
            .clk      (clk),
            .rst_n    (rst_n),
            .block    (data_index),
            .word_sel (data_word),
            .wr_en    (data_we[w]),
            .wr_data  (data_wr),
            .rd_data  (data_way[w])
        );

        meta_array u_meta (
            .clk      (clk),
            .rst_n    (rst_n),
            .index    (meta_index),
            .wr_en    (meta_we[w]),
            .wr_meta  (meta_wr),
            .rd_meta  (meta_way[w])
        );
    end

    assign hit       = |hit_way;
    assign read_hit  = read_en && hit;
    assign write_ok  = write_en && !fill_busy;
    assign write_hit = write_ok && hit;

    assign miss     = (read_en || write_en) && !hit;
    assign stall    = (read_en && !hit) || ((read_en || write_en) && fill_busy);
    assign data_out = read_hit ? (hit_way[1] ? data_way[1] : data_way[0]) : 16'h0000;

    // An empty way is taken first, starting with way 0.
    always_comb begin
        if (!meta_way[0].valid) begin
            victim_way = 1'b0;
        end else if (!meta_way[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = ~mru_q[addr.index];
        end
    end

    assign fill_start = read_en && !hit && !fill_busy;
    assign fill_addr  = {addr.tag, addr.index, 3'b000};

    always_comb begin
        mem_wr      = '0;
        mem_wr.we   = write_ok;
        mem_wr.addr = addr[15:1];
        mem_wr.data = data_in;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mru_q <= '0;
        end else if (meta_wr.valid) begin
            mru_q[fill_wr.index] <= fill_wr.way;
        end else if ((read_hit && !fill_busy) || write_hit) begin
            mru_q[addr.index] <= hit_way[1];
        end
    end

endmodule

/* hw/cache_fill_ctrl.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_fill_ctrl
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fill_start,
    input  logic [14:0] fill_addr,
    input  logic        victim_way,
    output logic        mem_rd_req,
    output logic [14:0] mem_rd_addr,
    input  logic        mem_rd_valid,
    input  logic [15:0] mem_rd_data,
    output logic        fill_busy,
    output fill_wr_t    fill_wr,
    output meta_t       meta_wr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_BURST
    } fill_state_t;

    fill_state_t state_q;
    logic [14:0] addr_q;
    logic        way_q;
    logic [2:0]  word_q;
    logic        last_word;

    assign fill_busy   = (state_q != ST_IDLE);
    assign mem_rd_req  = fill_busy;
    assign mem_rd_addr = addr_q;
    assign last_word   = fill_wr.we && (word_q == 3'(`CACHE_BLOCK_WORDS - 1));

    always_comb begin
        fill_wr          = '0;
        fill_wr.we       = fill_busy && mem_rd_valid;
        fill_wr.way      = way_q;
        fill_wr.index    = addr_q[8:3];
        fill_wr.word_sel = word_q;
        fill_wr.data     = mem_rd_data;
    end

    // The tag goes in with the last word, so the next lookup hits.
    always_comb begin
        meta_wr       = '0;
        meta_wr.valid = last_word;
        meta_wr.tag   = addr_q[14:9];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            word_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    word_q <= '0;
                    if (fill_start) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mem_rd_valid) begin
                        word_q  <= word_q + 3'd1;
                        state_q <= ST_BURST;
                    end
                end
                ST_BURST: begin
                    if (mem_rd_valid) begin
                        word_q <= word_q + 3'd1;
                        if (last_word) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && fill_start) begin
            addr_q <= fill_addr;
            way_q  <= victim_way;
        end
    end

endmodule

/* hw/main_memory.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module main_memory
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_wr_t     mem_wr,
    input  logic        mem_rd_req,
    input  logic [14:0] mem_rd_addr,
    output logic        mem_rd_valid,
    output logic [15:0] mem_rd_data
);

    logic [15:0] mem [`MEM_WORDS];

    logic       active_q;
    logic       done_q;
    logic [2:0] lat_q;
    logic [2:0] word_q;

    always_ff @(posedge clk) begin
        if (mem_wr.we) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // Words stream out back to back once the latency count runs out.
    assign mem_rd_valid = active_q && (lat_q == 3'd0);
    assign mem_rd_data  = mem_rd_valid ? mem[{mem_rd_addr[14:3], word_q}] : 16'h0000;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            lat_q    <= '0;
            word_q   <= '0;
        end else if (!active_q) begin
            word_q <= '0;
            if (!mem_rd_req) begin
                done_q <= 1'b0;
            end else if (!done_q) begin
                active_q <= 1'b1;
                lat_q    <= 3'(`MEM_LATENCY - 1);
            end
        end else if (lat_q != 3'd0) begin
            lat_q <= lat_q - 3'd1;
        end else begin
            word_q <= word_q + 3'd1;
            if (word_q == 3'(`CACHE_BLOCK_WORDS - 1)) begin
                active_q <= 1'b0;
                done_q   <= 1'b1;
            end
        end
    end

endmodule

/* hw/mem_system.sv */
`timescale 1ns/1ps

module mem_system
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] addr,
    input  logic [15:0] data_in,
    input  logic        read_en,
    input  logic        write_en,
    output logic [15:0] data_out,
    output logic        hit,
    output logic        miss,
    output logic        stall
);

    logic        fill_start;
    logic [14:0] fill_addr;
    logic        victim_way;
    logic        fill_busy;
    fill_wr_t    fill_wr;
    meta_t       meta_wr;
    mem_wr_t     mem_wr;
    logic        mem_rd_req;
    logic [14:0] mem_rd_addr;
    logic        mem_rd_valid;
    logic [15:0] mem_rd_data;

    d_cache u_d_cache (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .data_in    (data_in),
        .read_en    (read_en),
        .write_en   (write_en),
        .data_out   (data_out),
        .hit        (hit),
        .miss       (miss),
        .stall      (stall),
        .fill_busy  (fill_busy),
        .fill_wr    (fill_wr),
        .meta_wr    (meta_wr),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .victim_way (victim_way),
        .mem_wr     (mem_wr)
    );

    cache_fill_ctrl u_fill_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill_start   (fill_start),
        .fill_addr    (fill_addr),
        .victim_way   (victim_way),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .fill_busy    (fill_busy),
        .fill_wr      (fill_wr),
        .meta_wr      (meta_wr)
    );

    main_memory u_main_memory (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_wr       (mem_wr),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data)
    );

endmodule

/* tb/tb_mem_system.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_mem_system;

    localparam int DIRECTED_OPS    = 34;
    localparam int RAND_OPS        = 48;
    localparam int WATCHDOG_CYCLES = (DIRECTED_OPS + RAND_OPS) * (`MEM_LATENCY + 12) + 200;

    logic        clk;
    logic        rst_n;
    logic [15:0] addr;
    logic [15:0] data_in;
    logic        read_en;
    logic        write_en;
    logic [15:0] data_out;
    logic        hit;
    logic        miss;
    logic        stall;

    // Reference model of the cache state and of main memory.
    logic                       m_valid [2][`CACHE_SETS];
    logic [`CACHE_TAG_BITS-1:0] m_tag [2][`CACHE_SETS];
    logic                       m_mru [`CACHE_SETS];
    logic [15:0]                shadow [`MEM_WORDS];
    logic                       known [`MEM_WORDS];
    int                         fill_left;
    logic                       fill_way;
    logic [5:0]                 fill_index;
    logic [5:0]                 fill_tag;
    int                         stall_run;
    int                         op_count;
    int                         seed;

    mem_system u_mem_system (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .data_in  (data_in),
        .read_en  (read_en),
        .write_en (write_en),
        .data_out (data_out),
        .hit      (hit),
        .miss     (miss),
        .stall    (stall)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] make_addr(input logic [5:0] tag, input logic [5:0] index,
                                              input logic [2:0] word);
        return {tag, index, word, 1'b0};
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        read_en  = 1'b0;
        write_en = 1'b0;
    endtask

    // The address is held until a rising edge sees stall low.
    task automatic read_word(input logic [15:0] a);
        @(negedge clk);
        addr     = a;
        data_in  = 16'h0000;
        read_en  = 1'b1;
        write_en = 1'b0;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
        op_count++;
    endtask

    task automatic write_word(input logic [15:0] a, input logic [15:0] d);
        @(negedge clk);
        addr     = a;
        data_in  = d;
        read_en  = 1'b0;
        write_en = 1'b1;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
        op_count++;
    endtask

    always @(posedge clk) begin
        logic [5:0]  idx;
        logic [5:0]  tg;
        logic [14:0] waddr;
        logic [1:0]  way_hit;
        logic        busy;
        logic        exp_hit;
        logic        exp_miss;
        logic        exp_stall;
        if (!rst_n) begin
            fill_left = 0;
            stall_run = 0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                m_valid[0][s] = 1'b0;
                m_valid[1][s] = 1'b0;
                m_mru[s]      = 1'b0;
            end
            for (int k = 0; k < `MEM_WORDS; k++) begin
                known[k] = 1'b0;
            end
        end else begin
            idx        = addr[9:4];
            tg         = addr[15:10];
            waddr      = addr[15:1];
            busy       = (fill_left != 0);
            way_hit[0] = m_valid[0][idx] && (m_tag[0][idx] == tg);
            way_hit[1] = m_valid[1][idx] && (m_tag[1][idx] == tg);
            exp_hit    = |way_hit;
            exp_miss   = (read_en || write_en) && !exp_hit;
            exp_stall  = (read_en && !exp_hit) || ((read_en || write_en) && busy);

            assert (hit === exp_hit) else report_mismatch("hit", 16'(hit), 16'(exp_hit));
            assert (miss === exp_miss) else report_mismatch("miss", 16'(miss), 16'(exp_miss));
            assert (stall === exp_stall)
                else report_mismatch("stall", 16'(stall), 16'(exp_stall));
            assert (u_mem_system.mem_rd_req === busy)
                else report_mismatch("mem_rd_req", 16'(u_mem_system.mem_rd_req), 16'(busy));
            if (!(read_en && exp_hit)) begin
                assert (data_out === 16'h0000)
                    else report_mismatch("data_out", data_out, 16'h0000);
            end else if (known[waddr]) begin
                assert (data_out === shadow[waddr])
                    else report_mismatch("data_out", data_out, shadow[waddr]);
            end

            // A read miss keeps stall up for the whole fill and no longer.
            if (read_en && stall) begin
                stall_run++;
            end else begin
                if (read_en && hit && stall_run != 0) begin
                    assert (stall_run == `MEM_LATENCY + 9)
                        else report_mismatch("stall_cycles", 16'(stall_run),
                                             16'(`MEM_LATENCY + 9));
                end
                stall_run = 0;
            end

            if (busy) begin
                fill_left--;
                if (fill_left == 0) begin
                    m_valid[fill_way][fill_index] = 1'b1;
                    m_tag[fill_way][fill_index]   = fill_tag;
                    m_mru[fill_index]             = fill_way;
                end
            end else if (read_en && !exp_hit) begin
                fill_left  = `MEM_LATENCY + 8;
                fill_index = idx;
                fill_tag   = tg;
                if (!m_valid[0][idx]) begin
                    fill_way = 1'b0;
                end else if (!m_valid[1][idx]) begin
                    fill_way = 1'b1;
                end else begin
                    fill_way = !m_mru[idx];
                end
            end else if (read_en && exp_hit) begin
                m_mru[idx] = way_hit[1];
            end

            if (write_en && !busy) begin
                shadow[waddr] = data_in;
                known[waddr]  = 1'b1;
                if (exp_hit) begin
                    m_mru[idx] = way_hit[1];
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        logic [31:0] r;
        logic [15:0] a;
        clk      = 1'b0;
        rst_n    = 1'b0;
        addr     = 16'h0000;
        data_in  = 16'h0000;
        read_en  = 1'b0;
        write_en = 1'b0;
        op_count = 0;
        seed     = 36;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        idle_cycle();
        idle_cycle();

        read_word(make_addr(6'd0, 6'd0, 3'd0));
        for (int w = 0; w < `CACHE_BLOCK_WORDS; w++) begin
            r = $random(seed);
            write_word(make_addr(6'd1, 6'd10, 3'(w)), r[15:0]);
        end

        // Fill the block, then every word must hit.
        read_word(make_addr(6'd1, 6'd10, 3'd0));
        for (int w = 0; w < `CACHE_BLOCK_WORDS; w++) begin
            read_word(make_addr(6'd1, 6'd10, 3'(w)));
            idle_cycle();
        end

        write_word(make_addr(6'd1, 6'd10, 3'd3), 16'hbeef);
        read_word(make_addr(6'd1, 6'd10, 3'd3));

        // Three tags compete for the two ways of set 20.
        write_word(make_addr(6'd2, 6'd20, 3'd1), 16'h1111);
        write_word(make_addr(6'd3, 6'd20, 3'd1), 16'h2222);
        write_word(make_addr(6'd4, 6'd20, 3'd1), 16'h3333);
        read_word(make_addr(6'd2, 6'd20, 3'd1));
        read_word(make_addr(6'd3, 6'd20, 3'd1));
        read_word(make_addr(6'd2, 6'd20, 3'd1));
        read_word(make_addr(6'd4, 6'd20, 3'd1));
        read_word(make_addr(6'd2, 6'd20, 3'd1));
        read_word(make_addr(6'd3, 6'd20, 3'd1));

        // Evict the written block and bring it back from memory.
        read_word(make_addr(6'd5, 6'd10, 3'd0));
        read_word(make_addr(6'd6, 6'd10, 3'd0));
        read_word(make_addr(6'd1, 6'd10, 3'd3));

        r = $random(seed);
        write_word(make_addr(6'd7, 6'd30, 3'd5), r[15:0]);
        read_word(make_addr(6'd7, 6'd30, 3'd5));

        // A small address range keeps hits, misses and evictions all frequent.
        for (int i = 0; i < RAND_OPS; i++) begin
            r = $random(seed);
            a = make_addr({4'b0000, r[1:0]}, {4'b0000, r[3:2]}, r[6:4]);
            if (r[7]) begin
                write_word(a, r[31:16]);
            end else begin
                read_word(a);
            end
            if (r[8]) begin
                idle_cycle();
            end
        end
        idle_cycle();
        idle_cycle();

        $display("Completed %0d operations", op_count);
        $display("No errors");
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/cache_pkg.sv
hw/data_array.sv
hw/meta_array.sv
hw/d_cache.sv
hw/cache_fill_ctrl.sv
hw/main_memory.sv
hw/mem_system.sv
tb/tb_mem_system.sv

/* run.sh */
#!/bin/sh
# Compile the memory subsystem testbench with Verilator and run it.
# The run counts as passed only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module tb_mem_system \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_mem_system)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
